//--- src/z88_bus_pkg.sv
`default_nettype none

package z88_bus_pkg;

  typedef logic [15:0] cpu_addr_t;  // Z80 logical address
  typedef logic [21:0] mem_addr_t;  // Bank and offset, 4 MB space
  typedef logic [7:0]  bank_t;
  typedef logic [7:0]  byte_t;

  // Bank boundaries of the reduced map
  localparam bank_t RAM_FIRST_BANK = 8'h20;
  localparam bank_t BANK_LIMIT     = 8'h40;  // First unmapped bank

  // I/O ports, decoded on addr[7:0]
  localparam byte_t PORT_PB0L = 8'h70;
  localparam byte_t PORT_PB0H = 8'h71;
  localparam byte_t PORT_SBRL = 8'h74;
  localparam byte_t PORT_SBRH = 8'h75;
  localparam byte_t PORT_COM  = 8'hB0;
  localparam byte_t PORT_KBD  = 8'hB2;
  localparam byte_t PORT_SR0  = 8'hD0;  // SR0..SR3 on D0..D3
  localparam byte_t PORT_TIM0 = 8'hD0;  // Read side of D0
  localparam byte_t PORT_TIM1 = 8'hD1;

  typedef struct packed {
    cpu_addr_t addr;
    byte_t     wdata;
    logic      mreq_n;
    logic      iorq_n;
    logic      rd_n;
    logic      wr_n;
  } cpu_bus_t;

  // Toward the external ROM and RAM
  typedef struct packed {
    mem_addr_t ma;
    byte_t     wdata;
    logic      rom_ce_n;
    logic      ram_ce_n;
    logic      oe_n;
    logic      we_n;
  } mem_bus_t;

endpackage

`default_nettype wire

//--- src/z88_video_pkg.sv
`default_nettype none

package z88_video_pkg;

  localparam int GLYPH_LINES = 8;  // 8x8 glyphs

  typedef logic [12:0] font_base_t;    // PB0
  typedef logic [10:0] screen_base_t;  // SBR, 2 KB units
  typedef logic [13:0] vram_addr_t;

  typedef logic [2:0] glyph_line_t;
  typedef logic [3:0] nibble_t;   // 4 pixels per VRAM word
  typedef logic [5:0] pix_y_t;    // Row * 8 + line
  typedef logic [7:0] pix_x_t;    // Nibble column

  // VRAM write port, one nibble per cycle
  typedef struct packed {
    vram_addr_t addr;
    nibble_t    data;
    logic       we;
  } vram_wr_t;

  // Screen fetch request, served in phase 2
  typedef struct packed {
    z88_bus_pkg::mem_addr_t va;
    logic                   req;
  } video_req_t;

endpackage

`default_nettype wire

//--- src/blink_timer.sv
`default_nettype none

module blink_timer
  import z88_bus_pkg::*;
#(
  parameter int CLK_PER_5MS = 50000
) (
  input  wire        clk,
  input  wire        rst_n,
  output logic [1:0] clkcnt,
  output logic       pm1,
  output logic       t_5ms,
  output logic       t_1s,
  output byte_t      tick_cnt,
  output byte_t      sec_cnt
);

  localparam int    DIV_W         = (CLK_PER_5MS > 1) ? $clog2(CLK_PER_5MS) : 1;
  localparam byte_t TICKS_PER_SEC = 8'd200;

  logic [DIV_W-1:0] div_cnt;

  // Four phase slot counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clkcnt <= 2'd0;
      pm1    <= 1'b1;  // Slot 0 starts right out of reset
    end else begin
      clkcnt <= clkcnt + 2'd1;
      pm1    <= (clkcnt == 2'd3);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_cnt <= '0;
      t_5ms   <= 1'b0;
    end else if (div_cnt == DIV_W'(CLK_PER_5MS - 1)) begin
      div_cnt <= '0;
      t_5ms   <= 1'b1;
    end else begin
      div_cnt <= div_cnt + 1'b1;
      t_5ms   <= 1'b0;
    end
  end

  // 200 ticks make one second
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tick_cnt <= '0;
      sec_cnt  <= '0;
      t_1s     <= 1'b0;
    end else if (t_5ms) begin
      if (tick_cnt == TICKS_PER_SEC - 8'd1) begin
        tick_cnt <= '0;
        sec_cnt  <= sec_cnt + 8'd1;
        t_1s     <= ~t_1s;  // Level, one edge per second
      end else begin
        tick_cnt <= tick_cnt + 8'd1;
      end
    end
  end

  a_pm1_phase0: assert property (@(posedge clk) disable iff (!rst_n)
    pm1 |-> clkcnt == 2'd0);

endmodule

`default_nettype wire

//--- src/blink_mmu.sv
`default_nettype none

module blink_mmu
  import z88_bus_pkg::*;
  import z88_video_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire       [1:0] clkcnt,
  input  wire cpu_bus_t   cpu_bus,
  input  wire video_req_t video_req,
  output mem_bus_t        mem_bus,
  output logic            unmapped
);

  bank_t     sr [4];  // Segment registers SR0..SR3
  logic      cpu_phase;
  logic      vid_slot;
  logic      cpu_rd;
  logic      cpu_wr;
  logic      access;
  logic      sel_rom;
  logic      sel_ram;
  logic      sr_wr;
  mem_addr_t sel_addr;
  bank_t     sel_bank;

  assign cpu_phase = ~clkcnt[1];  // Phases 0 and 1
  assign vid_slot  = (clkcnt == 2'd2) && video_req.req;
  assign cpu_rd    = cpu_phase && !cpu_bus.mreq_n && !cpu_bus.rd_n;
  assign cpu_wr    = cpu_phase && !cpu_bus.mreq_n && !cpu_bus.wr_n;

  // Segment register write at the end of phase 1
  assign sr_wr = (clkcnt == 2'd1) && !cpu_bus.iorq_n && !cpu_bus.wr_n &&
                 (cpu_bus.addr[7:2] == PORT_SR0[7:2]);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++) begin
        sr[i] <= '0;
      end
    end else if (sr_wr) begin
      sr[cpu_bus.addr[1:0]] <= cpu_bus.wdata;
    end
  end

  // Video owns the bus in phase 2, otherwise the CPU address goes through its segment
  assign sel_addr = vid_slot ? video_req.va
                             : {sr[cpu_bus.addr[15:14]], cpu_bus.addr[13:0]};
  assign sel_bank = sel_addr[21:14];
  assign access   = vid_slot || cpu_rd || cpu_wr;

  assign sel_rom = access && (sel_bank < RAM_FIRST_BANK);
  assign sel_ram = access && (sel_bank >= RAM_FIRST_BANK) && (sel_bank < BANK_LIMIT);

  always_comb begin
    mem_bus.ma       = sel_addr;
    mem_bus.wdata    = cpu_bus.wdata;
    mem_bus.rom_ce_n = ~sel_rom;
    mem_bus.ram_ce_n = ~sel_ram;
    mem_bus.oe_n     = ~(vid_slot || cpu_rd);
    mem_bus.we_n     = ~(cpu_wr && sel_ram);  // ROM is never written
  end

  assign unmapped = cpu_rd && (sel_bank >= BANK_LIMIT);

  a_one_chip: assert property (@(posedge clk) disable iff (!rst_n)
    !(!mem_bus.rom_ce_n && !mem_bus.ram_ce_n));

endmodule

`default_nettype wire

//--- src/blink_io.sv
`default_nettype none

module blink_io
  import z88_bus_pkg::*;
  import z88_video_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,
  input  wire      [1:0] clkcnt,
  input  wire cpu_bus_t  cpu_bus,
  input  wire byte_t     mem_rdata,
  input  wire            unmapped,
  input  wire     [63:0] kbmatrix,
  input  wire byte_t     tick_cnt,
  input  wire byte_t     sec_cnt,
  output logic           lcdon,
  output font_base_t     pb0,
  output screen_base_t   sbr,
  output byte_t          cpu_rdata
);

  byte_t port;
  byte_t kbd_val;
  byte_t io_data;
  byte_t mem_data;
  logic  io_wr;
  logic  io_rd;
  logic  mem_rd;

  assign port   = cpu_bus.addr[7:0];
  assign io_wr  = (clkcnt == 2'd1) && !cpu_bus.iorq_n && !cpu_bus.wr_n;
  assign io_rd  = !cpu_bus.iorq_n && !cpu_bus.rd_n;
  assign mem_rd = !cpu_bus.mreq_n && !cpu_bus.rd_n;

  // COM, PB0 and SBR take the write at the end of phase 1
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lcdon <= 1'b0;
      pb0   <= '0;
      sbr   <= '0;
    end else if (io_wr) begin
      case (port)
        PORT_COM:  lcdon      <= cpu_bus.wdata[0];
        PORT_PB0L: pb0[7:0]   <= cpu_bus.wdata;
        PORT_PB0H: pb0[12:8]  <= cpu_bus.wdata[4:0];
        PORT_SBRL: sbr[7:0]   <= cpu_bus.wdata;
        PORT_SBRH: sbr[10:8]  <= cpu_bus.wdata[2:0];
        default: ;
      endcase
    end
  end

  // Rows selected by a 0 in addr[15:8], keys active low
  always_comb begin
    kbd_val = 8'hFF;
    for (int r = 0; r < 8; r++) begin
      if (!cpu_bus.addr[8+r]) begin
        kbd_val = kbd_val & kbmatrix[r*8 +: 8];
      end
    end
  end

  always_comb begin
    case (port)
      PORT_KBD:  io_data = kbd_val;
      PORT_TIM0: io_data = tick_cnt;   // 5 ms ticks, 0..199
      PORT_TIM1: io_data = sec_cnt;
      default:   io_data = 8'hFF;
    endcase
  end

  assign mem_data = unmapped ? 8'hFF : mem_rdata;  // Nothing answers above bank 3F

  always_comb begin
    if (io_rd) begin
      cpu_rdata = io_data;
    end else if (mem_rd) begin
      cpu_rdata = mem_data;
    end else begin
      cpu_rdata = 8'hFF;  // Floating bus
    end
  end

endmodule

`default_nettype wire

//--- src/lcd_screen.sv
`default_nettype none

module lcd_screen
  import z88_bus_pkg::*;
  import z88_video_pkg::*;
#(
  parameter int LCD_ROWS = 8,
  parameter int LCD_COLS = 64
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire          [1:0] clkcnt,
  input  wire                lcdon,
  input  wire                t_5ms,
  input  wire font_base_t    pb0,
  input  wire screen_base_t  sbr,
  input  wire byte_t         mem_rdata,
  output video_req_t         video_req,
  output vram_wr_t           vram_wr,
  output logic               frame
);

  localparam int ROW_W = (LCD_ROWS > 1) ? $clog2(LCD_ROWS) : 1;
  localparam int COL_W = (LCD_COLS > 1) ? $clog2(LCD_COLS) : 1;

  typedef enum logic [2:0] {
    IDLE,
    FETCH_CHAR,
    FETCH_GLYPH,
    WRITE_HI,
    WRITE_LO,
    DONE
  } state_t;

  state_t           state;
  logic [ROW_W-1:0] row;
  logic [COL_W-1:0] col;
  glyph_line_t      line;
  logic [10:0]      cell_off;  // Offset of the cell inside the SBR window
  byte_t            chr;
  byte_t            glyph;
  logic             vid_phase;
  logic             last_line;
  logic             last_col;
  logic             last_cell;
  pix_y_t           pix_y;
  pix_x_t           pix_x;

  assign vid_phase = (clkcnt == 2'd2);
  assign last_line = (line == glyph_line_t'(GLYPH_LINES - 1));
  assign last_col  = (col == COL_W'(LCD_COLS - 1));
  assign last_cell = (row == ROW_W'(LCD_ROWS - 1)) && last_col;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      row      <= '0;
      col      <= '0;
      line     <= '0;
      cell_off <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (t_5ms && lcdon) begin
            state    <= FETCH_CHAR;
            row      <= '0;
            col      <= '0;
            line     <= '0;
            cell_off <= '0;
          end
        end
        FETCH_CHAR:  if (vid_phase) state <= FETCH_GLYPH;
        FETCH_GLYPH: if (vid_phase) state <= WRITE_HI;
        WRITE_HI:    state <= WRITE_LO;  // Phase 3
        WRITE_LO: begin                  // Phase 0, next fetch fits the same slot grid
          if (!last_line) begin
            line  <= line + 3'd1;
            state <= FETCH_GLYPH;
          end else if (last_cell) begin
            line  <= '0;
            state <= DONE;
          end else begin
            line     <= '0;
            cell_off <= cell_off + 11'd1;
            state    <= FETCH_CHAR;
            if (last_col) begin
              col <= '0;
              row <= row + 1'b1;
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Fetched bytes, taken at the end of phase 2
  always_ff @(posedge clk) begin
    if (vid_phase && state == FETCH_CHAR) begin
      chr <= mem_rdata;
    end
    if (vid_phase && state == FETCH_GLYPH) begin
      glyph <= mem_rdata;
    end
  end

  always_comb begin
    video_req.req = vid_phase && (state == FETCH_CHAR || state == FETCH_GLYPH);
    if (state == FETCH_CHAR) begin
      video_req.va = {sbr, 11'd0} + mem_addr_t'(cell_off);
    end else begin
      video_req.va = {pb0, chr[5:0], line};  // Glyph line in the font
    end
  end

  assign pix_y = {3'(row), line};
  assign pix_x = {7'(col), state == WRITE_LO};  // Odd nibble holds the low half

  always_comb begin
    vram_wr.we   = (state == WRITE_HI) || (state == WRITE_LO);
    vram_wr.addr = {pix_y, pix_x};
    vram_wr.data = (state == WRITE_HI) ? glyph[7:4] : glyph[3:0];
  end

  assign frame = (state == DONE);

  a_req_phase2: assert property (@(posedge clk) disable iff (!rst_n)
    video_req.req |-> clkcnt == 2'd2);

endmodule

`default_nettype wire

//--- src/z88_soc.sv
`default_nettype none

module z88_soc
  import z88_bus_pkg::*;
  import z88_video_pkg::*;
#(
  parameter int CLK_PER_5MS = 50000,
  parameter int LCD_ROWS    = 8,
  parameter int LCD_COLS    = 64
) (
  input  wire            clk,
  input  wire            rst_n,
  input  wire cpu_bus_t  cpu_bus,
  input  wire byte_t     mem_rdata,
  input  wire     [63:0] kbmatrix,
  output mem_bus_t       mem_bus,
  output byte_t          cpu_rdata,
  output logic           pm1,
  output vram_wr_t       vram_wr,
  output logic           lcdon,
  output logic           frame,
  output logic           t_1s
);

  logic [1:0]   clkcnt;
  logic         t_5ms;
  logic         unmapped;
  byte_t        tick_cnt;
  byte_t        sec_cnt;
  font_base_t   pb0;
  screen_base_t sbr;
  video_req_t   video_req;

  blink_timer #(
    .CLK_PER_5MS(CLK_PER_5MS)
  ) timer_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .clkcnt  (clkcnt),
    .pm1     (pm1),
    .t_5ms   (t_5ms),
    .t_1s    (t_1s),
    .tick_cnt(tick_cnt),
    .sec_cnt (sec_cnt)
  );

  blink_mmu mmu_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .clkcnt   (clkcnt),
    .cpu_bus  (cpu_bus),
    .video_req(video_req),
    .mem_bus  (mem_bus),
    .unmapped (unmapped)
  );

  blink_io io_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .clkcnt   (clkcnt),
    .cpu_bus  (cpu_bus),
    .mem_rdata(mem_rdata),
    .unmapped (unmapped),
    .kbmatrix (kbmatrix),
    .tick_cnt (tick_cnt),
    .sec_cnt  (sec_cnt),
    .lcdon    (lcdon),
    .pb0      (pb0),
    .sbr      (sbr),
    .cpu_rdata(cpu_rdata)
  );

  lcd_screen #(
    .LCD_ROWS(LCD_ROWS),
    .LCD_COLS(LCD_COLS)
  ) screen_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .clkcnt   (clkcnt),
    .lcdon    (lcdon),
    .t_5ms    (t_5ms),
    .pb0      (pb0),
    .sbr      (sbr),
    .mem_rdata(mem_rdata),
    .video_req(video_req),
    .vram_wr  (vram_wr),
    .frame    (frame)
  );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/tb_z88_soc.sv
`default_nettype none

module tb_z88_soc
  import z88_bus_pkg::*;
  import z88_video_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PER_5MS  = 40;
  localparam int LCD_ROWS     = 2;
  localparam int LCD_COLS     = 4;
  localparam int FRAME_CYCLES = LCD_ROWS * LCD_COLS * 9 * 4;
  localparam int TEST_SLOTS   = 6000;
  localparam int TIMEOUT_NS   = (TEST_SLOTS * 4 + 4 * (FRAME_CYCLES + CLK_PER_5MS) + 2000) * 4;

  logic        clk;
  logic        rst_n;
  cpu_bus_t    cpu_bus;
  byte_t       mem_rdata;
  logic [63:0] kbmatrix;
  mem_bus_t    mem_bus;
  byte_t       cpu_rdata;
  logic        pm1;
  vram_wr_t    vram_wr;
  logic        lcdon;
  logic        frame;
  logic        t_1s;

  byte_t       ram [mem_addr_t];      // Memory model
  byte_t       exp_ram [mem_addr_t];  // Expected RAM contents
  nibble_t     vram [0:16383];
  bank_t       sr_model [4];
  logic [31:0] rand_state = 32'hc130_92b1;
  int          err_cnt = 0;
  int          wr_cnt = 0;
  int          frame_cnt = 0;
  int          first_frame_wr = 0;
  int          t1s_toggles = 0;
  logic        we_n_seen;
  byte_t       chars [LCD_ROWS*LCD_COLS];

  tb_clock clock_i (.clk(clk), .rst_n(rst_n));

  z88_soc #(
    .CLK_PER_5MS(CLK_PER_5MS),
    .LCD_ROWS   (LCD_ROWS),
    .LCD_COLS   (LCD_COLS)
  ) dut_i (
    .clk(clk), .rst_n(rst_n), .cpu_bus(cpu_bus), .mem_rdata(mem_rdata),
    .kbmatrix(kbmatrix), .mem_bus(mem_bus), .cpu_rdata(cpu_rdata), .pm1(pm1),
    .vram_wr(vram_wr), .lcdon(lcdon), .frame(frame), .t_1s(t_1s)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rand_state = xorshift(rand_state);
    return rand_state;
  endfunction

  function automatic byte_t rom_byte(input mem_addr_t a);
    logic [31:0] h;
    h = xorshift({10'd0, a} ^ 32'h9e37_79b9);
    return h[7:0];
  endfunction

  function automatic byte_t ram_fill(input mem_addr_t a);
    return rom_byte(a) ^ 8'ha5;  // Power-up contents
  endfunction

  function automatic mem_addr_t map_addr(input cpu_addr_t a);
    return {sr_model[a[15:14]], a[13:0]};
  endfunction

  function automatic byte_t exp_mem(input mem_addr_t pa);
    if (pa[21:14] < 8'h20) return rom_byte(pa);
    if (pa[21:14] >= 8'h40) return 8'hff;
    return exp_ram.exists(pa) ? exp_ram[pa] : ram_fill(pa);
  endfunction

  function automatic byte_t kbd_scan(input logic [63:0] kb, input byte_t rows_n);
    byte_t v;
    v = 8'hff;
    for (int r = 0; r < 8; r++) begin
      if (!rows_n[r]) v = v & kb[r*8 +: 8];
    end
    return v;
  endfunction

  function automatic nibble_t glyph_nibble(input font_base_t pb, input byte_t ch,
                                           input glyph_line_t ln, input logic lo);
    byte_t g;
    g = rom_byte({pb, ch[5:0], ln});
    return lo ? g[3:0] : g[7:4];
  endfunction

  // External ROM and RAM answer combinationally
  always_comb begin
    if (!mem_bus.rom_ce_n) mem_rdata = rom_byte(mem_bus.ma);
    else if (!mem_bus.ram_ce_n) mem_rdata = ram.exists(mem_bus.ma) ? ram[mem_bus.ma]
                                                                    : ram_fill(mem_bus.ma);
    else mem_rdata = 8'h00;  // No chip selected
  end

  always @(posedge clk) begin
    if (rst_n && !mem_bus.we_n && !mem_bus.ram_ce_n) ram[mem_bus.ma] = mem_bus.wdata;
  end

  // VRAM model plus write and frame counters
  always @(posedge clk) begin
    if (rst_n) begin
      if (vram_wr.we) begin
        vram[vram_wr.addr] = vram_wr.data;
        wr_cnt++;
      end
      if (frame) begin
        if (frame_cnt == 0) first_frame_wr = wr_cnt;
        frame_cnt++;
      end
    end
  end

  always @(t_1s) if (rst_n === 1'b1) t1s_toggles++;

  task automatic fail_now(input string msg);
    $display("[ERROR] t=%0t %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input string what, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      err_cnt++;
      fail_now($sformatf("%s: got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_vram(input vram_addr_t a, input nibble_t got, input nibble_t exp);
    if (got !== exp) begin
      err_cnt++;
      fail_now($sformatf("VRAM %h: got %h expected %h", a, got, exp));
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      err_cnt++;
      fail_now($sformatf("%s: got %0d expected %0d", what, got, exp));
    end
  endtask

  // One CPU slot, driven on the edge that ends pm1, sampled in phase 1
  task automatic bus_cycle(input cpu_bus_t b);
    @(posedge clk);
    while (!pm1) @(posedge clk);
    cpu_bus <= b;
    @(negedge clk);
    we_n_seen = mem_bus.we_n;
  endtask

  task automatic idle_slots(input int n);
    cpu_bus_t b;
    b = '{addr: 16'h0, wdata: 8'h0, mreq_n: 1'b1, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
    repeat (n) bus_cycle(b);
  endtask

  task automatic cpu_write(input logic io, input cpu_addr_t a, input byte_t d);
    cpu_bus_t b;
    b = '{addr: a, wdata: d, mreq_n: io, iorq_n: !io, rd_n: 1'b1, wr_n: 1'b0};
    bus_cycle(b);
    if (!io && map_addr(a) >= 22'h08_0000 && map_addr(a) < 22'h10_0000) begin
      exp_ram[map_addr(a)] = d;
    end
  endtask

  task automatic cpu_read(input logic io, input cpu_addr_t a, output byte_t d);
    cpu_bus_t b;
    b = '{addr: a, wdata: 8'h0, mreq_n: io, iorq_n: !io, rd_n: 1'b0, wr_n: 1'b1};
    bus_cycle(b);
    d = cpu_rdata;
  endtask

  task automatic set_sr(input int i, input bank_t bank);
    cpu_write(1'b1, 16'(8'hd0 + i), bank);
    sr_model[i] = bank;
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish in the expected time");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    cpu_addr_t   a;
    byte_t       d;
    byte_t       d2;
    logic [31:0] r;
    mem_addr_t   q_addr [$];
    byte_t       tick0;
    byte_t       sec0;
    int          tog0;
    int          total;
    font_base_t  pb;
    vram_addr_t  va;

    cpu_bus  = '{addr: 16'h0, wdata: 8'h0, mreq_n: 1'b1, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
    kbmatrix = '1;
    for (int i = 0; i < 4; i++) sr_model[i] = 8'h00;
    wait (rst_n === 1'b1);
    check_count("lcdon after reset", int'(lcdon), 0);

    // Bank mapping with ROM, RAM and unmapped banks
    repeat (4) begin
      for (int i = 0; i < 4; i++) begin
        r = next_rand();
        set_sr(i, (r[9:8] == 2'd0) ? r[7:0] : {2'b00, r[5:0]});
      end
      repeat (16) begin
        a = cpu_addr_t'(next_rand());
        cpu_read(1'b0, a, d);
        check_byte($sformatf("read %h", a), d, exp_mem(map_addr(a)));
      end
    end

    // RAM write and read back, ROM stays write protected
    set_sr(2, 8'h20 | (bank_t'(next_rand()) & 8'h1f));
    repeat (32) begin
      a = 16'h8000 | (cpu_addr_t'(next_rand()) & 16'h3fff);
      cpu_write(1'b0, a, byte_t'(next_rand()));
      q_addr.push_back({2'b00, a[13:0]});
    end
    foreach (q_addr[k]) begin
      cpu_read(1'b0, 16'h8000 | 16'(q_addr[k][13:0]), d);
      check_byte("RAM read back", d, exp_mem(map_addr(16'h8000 | 16'(q_addr[k][13:0]))));
    end
    set_sr(3, bank_t'(next_rand()) & 8'h1f);
    a = 16'hc000 | (cpu_addr_t'(next_rand()) & 16'h3fff);
    cpu_write(1'b0, a, 8'h5a);
    check_count("we_n on ROM write", int'(we_n_seen), 1);
    cpu_read(1'b0, a, d);
    check_byte("ROM after write", d, rom_byte(map_addr(a)));

    // Keyboard scan
    repeat (4) begin
      @(posedge clk);
      while (!pm1) @(posedge clk);
      kbmatrix <= {next_rand(), next_rand()};
      repeat (8) begin
        a = {byte_t'(next_rand()), 8'hb2};
        cpu_read(1'b1, a, d);
        check_byte("keyboard", d, kbd_scan(kbmatrix, a[15:8]));
      end
    end

    // Timer, synchronized just after a tick
    cpu_read(1'b1, 16'h00d0, d);
    do begin
      d2 = d;
      cpu_read(1'b1, 16'h00d0, d);
    end while (d == d2);
    tick0 = d;
    tog0  = t1s_toggles;
    cpu_read(1'b1, 16'h00d1, sec0);
    idle_slots(4198);  // 4200 slots between tick reads, 420 ticks
    cpu_read(1'b1, 16'h00d0, d);
    cpu_read(1'b1, 16'h00d1, d2);
    total = int'(sec0) * 200 + int'(tick0) + 420;
    check_byte("tick count", d, byte_t'(total % 200));
    check_byte("seconds", d2, byte_t'(total / 200));
    check_count("t_1s edges", t1s_toggles - tog0, (int'(tick0) + 420) / 200);

    // Screen stays dark with LCD off
    check_count("VRAM writes with LCD off", wr_cnt, 0);
    check_count("frames with LCD off", frame_cnt, 0);
    set_sr(1, 8'h21);
    for (int i = 0; i < LCD_ROWS * LCD_COLS; i++) begin
      chars[i] = byte_t'(next_rand());
      cpu_write(1'b0, 16'(16'h4000 + i), chars[i]);
    end
    pb = font_base_t'(next_rand()) & 13'h03ff;  // Font in ROM
    cpu_write(1'b1, 16'h0070, pb[7:0]);
    cpu_write(1'b1, 16'h0071, {3'b000, pb[12:8]});
    cpu_write(1'b1, 16'h0074, 8'h08);  // SBR 108, bank 21
    cpu_write(1'b1, 16'h0075, 8'h01);
    cpu_write(1'b1, 16'h00b0, 8'h01);
    wait (frame_cnt >= 1);
    check_count("lcdon during frame", int'(lcdon), 1);
    cpu_write(1'b1, 16'h00b0, 8'h00);
    check_count("writes in one frame", first_frame_wr, LCD_ROWS * LCD_COLS * 16);
    for (int row = 0; row < LCD_ROWS; row++) begin
      for (int col = 0; col < LCD_COLS; col++) begin
        for (int ln = 0; ln < 8; ln++) begin
          for (int lo = 0; lo < 2; lo++) begin
            va = {6'(row * 8 + ln), 8'(col * 2 + lo)};
            check_vram(va, vram[va], glyph_nibble(pb, chars[row*LCD_COLS+col],
                                                  glyph_line_t'(ln), lo[0]));
          end
        end
      end
    end
    idle_slots(200);  // Let a frame in flight finish
    total = wr_cnt;
    tog0  = frame_cnt;
    idle_slots(200);
    check_count("lcdon after COM write", int'(lcdon), 0);
    check_count("VRAM writes after LCD off", wr_cnt, total);
    check_count("frames after LCD off", frame_cnt, tog0);

    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
src/z88_bus_pkg.sv
src/z88_video_pkg.sv
src/blink_timer.sv
src/blink_mmu.sv
src/blink_io.sv
src/lcd_screen.sv
src/z88_soc.sv
sim/tb_clock.sv
sim/tb_z88_soc.sv

//--- run_sim.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -f filelist.f --top-module tb_z88_soc -o sim_z88
./obj_dir/sim_z88 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
exit 0
